//--- verilog/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN      32
`define RV_NREGS     32
`define RV_RESET_PC  32'h0000_0000
`define RV_TRAP_VEC  32'h0000_0100

`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011

`define RV_F3_BEQ    3'b000
`define RV_F3_BNE    3'b001
`define RV_F3_BLT    3'b100
`define RV_F3_BGE    3'b101
`define RV_F3_BLTU   3'b110
`define RV_F3_BGEU   3'b111

// low two funct3 bits of loads and stores
`define RV_SZ_BYTE   2'b00
`define RV_SZ_HALF   2'b01
`define RV_SZ_WORD   2'b10

// low three bits follow funct3 of OP/OP-IMM, bit 3 is funct7[5]
`define RV_ALU_ADD   4'h0
`define RV_ALU_SLL   4'h1
`define RV_ALU_SLT   4'h2
`define RV_ALU_SLTU  4'h3
`define RV_ALU_XOR   4'h4
`define RV_ALU_SRL   4'h5
`define RV_ALU_OR    4'h6
`define RV_ALU_AND   4'h7
`define RV_ALU_SUB   4'h8
`define RV_ALU_EQ    4'h9
`define RV_ALU_NE    4'ha
`define RV_ALU_LT    4'hb
`define RV_ALU_GE    4'hc
`define RV_ALU_SRA   4'hd
`define RV_ALU_LTU   4'he
`define RV_ALU_GEU   4'hf

`endif

//--- verilog/rv_isa_pkg.sv
`include "rv_defs.svh"

package rv_isa_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [3:0] alu_op_t;

	typedef struct packed {
		reg_idx_t   rd;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		word_t      imm;
		alu_op_t    alu_op;
		logic       use_imm;     // alu operand 2 from imm
		logic       wr_rd;
		logic       is_load;
		logic       is_store;
		logic [1:0] mem_size;
		logic       is_unsigned;
		logic       is_branch;
		logic       is_jal;
		logic       is_jalr;
		logic       is_lui;
		logic       is_auipc;
		logic       illegal;
	} dec_t;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_DECODE,
		ST_EXEC,
		ST_MEM,
		ST_WRITE,
		ST_TRAP
	} core_state_t;

endpackage

//--- verilog/rv_bus_pkg.sv
package rv_bus_pkg;
	import rv_isa_pkg::*;

	typedef logic [3:0] strb_t;
	typedef logic [1:0] axi_resp_t;

	// master to slave
	typedef struct packed {
		logic  ar_valid;
		word_t ar_addr;
		logic  r_ready;
		logic  aw_valid;
		word_t aw_addr;
		logic  w_valid;
		word_t w_data;
		strb_t w_strb;
		logic  b_ready;
	} axi_req_t;

	typedef struct packed {
		logic      ar_ready;
		logic      r_valid;
		word_t     r_data;
		axi_resp_t r_resp;
		logic      aw_ready;
		logic      w_ready;
		logic      b_valid;
		axi_resp_t b_resp;
	} axi_rsp_t;

	// lsu request kinds
	localparam logic [1:0] LSU_FETCH = 2'd0;
	localparam logic [1:0] LSU_LOAD  = 2'd1;
	localparam logic [1:0] LSU_STORE = 2'd2;

endpackage

//--- verilog/rv_decoder.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_decoder
	import rv_isa_pkg::*;
(
	input  logic  clk,
	input  logic  rstn,
	input  word_t instr,
	output dec_t  dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	alu_op_t    alu_base;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;
	dec_t       d;

	assign opcode   = instr[6:0];
	assign funct3   = instr[14:12];
	assign funct7   = instr[31:25];
	assign alu_base = {1'b0, funct3};

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		d = '0;
		d.rd = instr[11:7];
		d.rs1 = instr[19:15];
		d.rs2 = instr[24:20];
		d.mem_size = funct3[1:0];
		d.is_unsigned = funct3[2];
		d.alu_op = `RV_ALU_ADD;
		case (opcode)
			`RV_OP_LUI: begin
				d.is_lui = 1'b1;
				d.wr_rd = 1'b1;
				d.imm = imm_u;
			end
			`RV_OP_AUIPC: begin
				d.is_auipc = 1'b1;
				d.wr_rd = 1'b1;
				d.imm = imm_u;
			end
			`RV_OP_JAL: begin
				d.is_jal = 1'b1;
				d.wr_rd = 1'b1;
				d.imm = imm_j;
			end
			`RV_OP_JALR: begin
				d.is_jalr = 1'b1;
				d.wr_rd = 1'b1;
				d.use_imm = 1'b1;     // target is rs1 + imm
				d.imm = imm_i;
				d.illegal = funct3 != 3'b000;
			end
			`RV_OP_BRANCH: begin
				d.is_branch = 1'b1;
				d.imm = imm_b;
				case (funct3)
					`RV_F3_BEQ:  d.alu_op = `RV_ALU_EQ;
					`RV_F3_BNE:  d.alu_op = `RV_ALU_NE;
					`RV_F3_BLT:  d.alu_op = `RV_ALU_LT;
					`RV_F3_BGE:  d.alu_op = `RV_ALU_GE;
					`RV_F3_BLTU: d.alu_op = `RV_ALU_LTU;
					`RV_F3_BGEU: d.alu_op = `RV_ALU_GEU;
					default:     d.illegal = 1'b1;
				endcase
			end
			`RV_OP_LOAD: begin
				d.is_load = 1'b1;
				d.wr_rd = 1'b1;
				d.use_imm = 1'b1;
				d.imm = imm_i;
				d.illegal = (funct3[1:0] == 2'b11) || (funct3 == {1'b1, `RV_SZ_WORD});
			end
			`RV_OP_STORE: begin
				d.is_store = 1'b1;
				d.use_imm = 1'b1;
				d.imm = imm_s;
				d.illegal = funct3[2] || (funct3[1:0] == 2'b11);
			end
			`RV_OP_IMM: begin
				d.wr_rd = 1'b1;
				d.use_imm = 1'b1;
				d.imm = imm_i;
				d.alu_op = alu_base;
				if (alu_base == `RV_ALU_SLL) begin
					d.illegal = funct7 != 7'b0;
				end else if (alu_base == `RV_ALU_SRL) begin
					d.alu_op = {funct7[5], funct3};   // srai when funct7[5]
					d.illegal = (funct7 & 7'b1011111) != 7'b0;
				end
			end
			`RV_OP_REG: begin
				d.wr_rd = 1'b1;
				d.alu_op = {funct7[5], funct3};
				d.illegal = ((funct7 & 7'b1011111) != 7'b0) ||
					(funct7[5] && alu_base != `RV_ALU_ADD && alu_base != `RV_ALU_SRL);
			end
			default: d.illegal = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			dec <= '0;
		end else begin
			dec <= d;
		end
	end

endmodule

//--- verilog/rv_regfile.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_regfile
	import rv_isa_pkg::*;
(
	input  logic     clk,
	input  logic     rstn,
	input  reg_idx_t rs1_idx,
	input  reg_idx_t rs2_idx,
	output word_t    rs1_val,
	output word_t    rs2_val,
	input  logic     wr_en,
	input  reg_idx_t wr_idx,
	input  word_t    wr_data
);

	word_t regs [1:`RV_NREGS-1];     // x0 has no storage

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 1; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		rs1_val <= (rs1_idx == '0) ? '0 : regs[rs1_idx];
		rs2_val <= (rs2_idx == '0) ? '0 : regs[rs2_idx];
	end

	// x0 read right after a write to x0 still gives zero
	assert property (@(posedge clk) disable iff (!rstn)
		(wr_en && wr_idx == '0) ##1 (rs1_idx == '0) |=> (rs1_val == '0));

endmodule

//--- verilog/rv_alu.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_alu
	import rv_isa_pkg::*;
(
	input  logic    clk,
	input  logic    rstn,
	input  alu_op_t op,
	input  word_t   src1,
	input  word_t   src2,
	output word_t   result
);

	logic [4:0] shamt;
	logic       eq;
	logic       lt_s;
	logic       lt_u;
	word_t      res;

	assign shamt = src2[4:0];
	assign eq    = src1 == src2;
	assign lt_s  = $signed(src1) < $signed(src2);
	assign lt_u  = src1 < src2;

	always_comb begin
		case (op)
			`RV_ALU_ADD:  res = src1 + src2;
			`RV_ALU_SUB:  res = src1 - src2;
			`RV_ALU_XOR:  res = src1 ^ src2;
			`RV_ALU_OR:   res = src1 | src2;
			`RV_ALU_AND:  res = src1 & src2;
			`RV_ALU_SLL:  res = src1 << shamt;
			`RV_ALU_SRL:  res = src1 >> shamt;
			`RV_ALU_SRA:  res = word_t'($signed(src1) >>> shamt);
			`RV_ALU_SLT:  res = word_t'(lt_s);
			`RV_ALU_SLTU: res = word_t'(lt_u);
			`RV_ALU_EQ:   res = word_t'(eq);     // branch compares give 0 or 1
			`RV_ALU_NE:   res = word_t'(!eq);
			`RV_ALU_LT:   res = word_t'(lt_s);
			`RV_ALU_GE:   res = word_t'(!lt_s);
			`RV_ALU_LTU:  res = word_t'(lt_u);
			`RV_ALU_GEU:  res = word_t'(!lt_u);
			default:      res = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			result <= '0;
		end else begin
			result <= res;
		end
	end

endmodule

//--- verilog/rv_lsu.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_lsu
	import rv_isa_pkg::*;
	import rv_bus_pkg::*;
(
	input  logic       clk,
	input  logic       rstn,
	input  logic       start,
	input  logic [1:0] kind,
	input  word_t      addr,
	input  word_t      wdata,
	input  logic [1:0] size,
	input  logic       is_unsigned,
	output logic       done,
	output word_t      rdata,
	output logic       misaligned,
	output axi_req_t   m_req,
	input  axi_rsp_t   m_rsp
);

	typedef enum logic [2:0] {
		L_IDLE,
		L_AR,
		L_R,
		L_W,
		L_B
	} lsu_state_t;

	lsu_state_t state;
	logic [1:0] eff_size;
	logic [1:0] off_q;
	logic [1:0] size_q;
	logic       uns_q;
	logic       mis;
	logic       aw_done;
	logic       w_done;
	word_t      st_data;
	strb_t      st_strb;
	word_t      rd_word;
	word_t      ld_data;

	assign eff_size = (kind == LSU_FETCH) ? `RV_SZ_WORD : size;   // fetch is always a word
	assign aw_done  = !m_req.aw_valid || m_rsp.aw_ready;
	assign w_done   = !m_req.w_valid || m_rsp.w_ready;

	always_comb begin
		case (eff_size)
			`RV_SZ_BYTE: begin
				mis = 1'b0;
				st_data = {4{wdata[7:0]}};
				st_strb = strb_t'(4'b0001) << addr[1:0];
			end
			`RV_SZ_HALF: begin
				mis = addr[0];
				st_data = {2{wdata[15:0]}};
				st_strb = strb_t'(4'b0011) << addr[1:0];
			end
			`RV_SZ_WORD: begin
				mis = addr[1:0] != 2'b00;
				st_data = wdata;
				st_strb = 4'b1111;
			end
			default: begin
				mis = 1'b1;
				st_data = wdata;
				st_strb = 4'b0000;
			end
		endcase
	end

	// little-endian lane select, then sign or zero extend
	always_comb begin
		rd_word = m_rsp.r_data >> {off_q, 3'b000};
		case (size_q)
			`RV_SZ_BYTE: ld_data = {{24{~uns_q & rd_word[7]}}, rd_word[7:0]};
			`RV_SZ_HALF: ld_data = {{16{~uns_q & rd_word[15]}}, rd_word[15:0]};
			default:     ld_data = rd_word;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= L_IDLE;
			m_req.ar_valid <= 1'b0;
			m_req.r_ready <= 1'b0;
			m_req.aw_valid <= 1'b0;
			m_req.w_valid <= 1'b0;
			m_req.b_ready <= 1'b0;
			done <= 1'b0;
			misaligned <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				L_IDLE: begin
					if (start) begin
						off_q <= addr[1:0];
						size_q <= eff_size;
						uns_q <= is_unsigned;
						misaligned <= mis;
						if (mis) begin
							done <= 1'b1;     // no bus beat
						end else if (kind == LSU_STORE) begin
							m_req.aw_valid <= 1'b1;
							m_req.aw_addr <= {addr[`RV_XLEN-1:2], 2'b00};
							m_req.w_valid <= 1'b1;
							m_req.w_data <= st_data;
							m_req.w_strb <= st_strb;
							state <= L_W;
						end else begin
							m_req.ar_valid <= 1'b1;
							m_req.ar_addr <= {addr[`RV_XLEN-1:2], 2'b00};
							state <= L_AR;
						end
					end
				end
				L_AR: begin
					if (m_rsp.ar_ready) begin
						m_req.ar_valid <= 1'b0;
						m_req.r_ready <= 1'b1;
						state <= L_R;
					end
				end
				L_R: begin
					if (m_rsp.r_valid) begin
						m_req.r_ready <= 1'b0;
						rdata <= ld_data;
						done <= 1'b1;
						state <= L_IDLE;
					end
				end
				L_W: begin
					if (m_rsp.aw_ready) begin
						m_req.aw_valid <= 1'b0;
					end
					if (m_rsp.w_ready) begin
						m_req.w_valid <= 1'b0;
					end
					if (aw_done && w_done) begin
						m_req.b_ready <= 1'b1;
						state <= L_B;
					end
				end
				L_B: begin
					if (m_rsp.b_valid) begin
						m_req.b_ready <= 1'b0;
						done <= 1'b1;
						state <= L_IDLE;
					end
				end
				default: state <= L_IDLE;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rstn)
		(m_req.ar_valid && !m_rsp.ar_ready) |=> (m_req.ar_valid && $stable(m_req.ar_addr)));

	assert property (@(posedge clk) disable iff (!rstn)
		(m_req.aw_valid && !m_rsp.aw_ready) |=> (m_req.aw_valid && $stable(m_req.aw_addr)));

endmodule

//--- verilog/rv_core.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_core
	import rv_isa_pkg::*;
	import rv_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rstn,
	output axi_req_t m_req,
	input  axi_rsp_t m_rsp
);

	core_state_t state;
	word_t       pc;
	word_t       instr_q;
	word_t       dec_in;
	dec_t        dec;
	word_t       rs1_val;
	word_t       rs2_val;
	word_t       alu_src2;
	word_t       alu_result;
	word_t       pc_imm;
	word_t       pc_plus4;
	word_t       next_pc;
	word_t       wb_data;
	logic        rf_wr_en;
	logic        lsu_start;
	logic        lsu_busy;
	logic        lsu_done;
	logic        lsu_misaligned;
	logic [1:0]  lsu_kind;
	word_t       lsu_addr;
	word_t       lsu_rdata;

	// the fetched word goes straight to the decoder so dec is ready at decode
	assign dec_in   = (state == ST_FETCH) ? lsu_rdata : instr_q;
	assign alu_src2 = dec.use_imm ? dec.imm : rs2_val;
	assign pc_imm   = pc + dec.imm;
	assign pc_plus4 = pc + 32'd4;
	assign rf_wr_en = (state == ST_WRITE) && dec.wr_rd;

	assign lsu_start = (state == ST_FETCH || state == ST_MEM) && !lsu_busy;
	assign lsu_kind  = (state == ST_FETCH) ? LSU_FETCH : (dec.is_store ? LSU_STORE : LSU_LOAD);
	assign lsu_addr  = (state == ST_FETCH) ? pc : alu_result;   // alu holds rs1 + imm

	always_comb begin
		if (dec.is_lui) begin
			wb_data = dec.imm;
		end else if (dec.is_auipc) begin
			wb_data = pc_imm;
		end else if (dec.is_load) begin
			wb_data = lsu_rdata;
		end else if (dec.is_jal || dec.is_jalr) begin
			wb_data = pc_plus4;     // link
		end else begin
			wb_data = alu_result;
		end
	end

	always_comb begin
		if (dec.is_jal) begin
			next_pc = pc_imm;
		end else if (dec.is_jalr) begin
			next_pc = {alu_result[`RV_XLEN-1:1], 1'b0};
		end else if (dec.is_branch && alu_result[0]) begin
			next_pc = pc_imm;
		end else begin
			next_pc = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			lsu_busy <= 1'b0;
		end else if (lsu_done) begin
			lsu_busy <= 1'b0;
		end else if (lsu_start) begin
			lsu_busy <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ST_FETCH;
			pc <= `RV_RESET_PC;
		end else begin
			case (state)
				ST_FETCH: begin
					if (lsu_done) begin
						instr_q <= lsu_rdata;
						state <= lsu_misaligned ? ST_TRAP : ST_DECODE;
					end
				end
				ST_DECODE: state <= ST_EXEC;
				ST_EXEC: begin
					if (dec.illegal) begin
						state <= ST_TRAP;
					end else if (dec.is_load || dec.is_store) begin
						state <= ST_MEM;
					end else begin
						state <= ST_WRITE;
					end
				end
				ST_MEM: begin
					if (lsu_done) begin
						state <= lsu_misaligned ? ST_TRAP : ST_WRITE;
					end
				end
				ST_WRITE: begin
					pc <= next_pc;
					state <= ST_FETCH;
				end
				ST_TRAP: begin
					pc <= `RV_TRAP_VEC;
					state <= ST_FETCH;
				end
				default: state <= ST_FETCH;
			endcase
		end
	end

	rv_decoder u_decoder (
		.clk   (clk),
		.rstn  (rstn),
		.instr (dec_in),
		.dec   (dec)
	);

	rv_regfile u_regfile (
		.clk     (clk),
		.rstn    (rstn),
		.rs1_idx (dec.rs1),
		.rs2_idx (dec.rs2),
		.rs1_val (rs1_val),
		.rs2_val (rs2_val),
		.wr_en   (rf_wr_en),
		.wr_idx  (dec.rd),
		.wr_data (wb_data)
	);

	rv_alu u_alu (
		.clk    (clk),
		.rstn   (rstn),
		.op     (dec.alu_op),
		.src1   (rs1_val),
		.src2   (alu_src2),
		.result (alu_result)
	);

	rv_lsu u_lsu (
		.clk         (clk),
		.rstn        (rstn),
		.start       (lsu_start),
		.kind        (lsu_kind),
		.addr        (lsu_addr),
		.wdata       (rs2_val),
		.size        (dec.mem_size),
		.is_unsigned (dec.is_unsigned),
		.done        (lsu_done),
		.rdata       (lsu_rdata),
		.misaligned  (lsu_misaligned),
		.m_req       (m_req),
		.m_rsp       (m_rsp)
	);

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	input  logic restart,
	output logic clk,
	output logic rstn
);

	int cnt;

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;     // 8 ns period
	end

	always @(posedge clk) begin
		if (restart) begin
			cnt <= 0;
		end else if (cnt < 16) begin
			cnt <= cnt + 1;
		end
	end

	assign #1 rstn = (cnt >= 16);     // low for 16 cycles after restart drops

endmodule

//--- tb/tb_axi_mem.sv
`timescale 1ns/100ps

module tb_axi_mem
	import rv_isa_pkg::*;
	import rv_bus_pkg::*;
(
	input  logic     clk,
	input  logic     rstn,
	input  logic     rand_en,
	input  axi_req_t req,
	output axi_rsp_t rsp
);

	typedef enum logic [1:0] {
		M_IDLE,
		M_RDATA,
		M_WRESP
	} mem_state_t;

	word_t      mem [0:1023];
	mem_state_t state;
	axi_rsp_t   r;
	logic [9:0] rd_idx;
	int         dly;
	int         seed;

	initial seed = 15;

	assign #1 rsp = r;     // responses change just after the edge

	function automatic int pick_delay();
		if (!rand_en) begin
			return 0;
		end
		return int'($unsigned($random(seed)) % 4);
	endfunction

	always @(posedge clk) begin
		if (!rstn) begin
			r <= '0;
			state <= M_IDLE;
			dly <= 0;
		end else begin
			r.ar_ready <= 1'b0;
			r.aw_ready <= 1'b0;
			r.w_ready <= 1'b0;
			case (state)
				M_IDLE: begin
					if (r.ar_ready) begin     // address beat taken here
						rd_idx <= req.ar_addr[11:2];
						state <= M_RDATA;
						dly <= pick_delay();
					end else if (r.aw_ready) begin
						for (int i = 0; i < 4; i++) begin
							if (req.w_strb[i]) begin
								mem[req.aw_addr[11:2]][8*i +: 8] = req.w_data[8*i +: 8];
							end
						end
						state <= M_WRESP;
						dly <= pick_delay();
					end else if (req.ar_valid || (req.aw_valid && req.w_valid)) begin
						if (dly > 0) begin
							dly <= dly - 1;
						end else if (req.ar_valid) begin
							r.ar_ready <= 1'b1;
						end else begin
							r.aw_ready <= 1'b1;
							r.w_ready <= 1'b1;
						end
					end
				end
				M_RDATA: begin
					if (r.r_valid) begin
						if (req.r_ready) begin
							r.r_valid <= 1'b0;
							state <= M_IDLE;
							dly <= pick_delay();
						end
					end else if (dly > 0) begin
						dly <= dly - 1;
					end else begin
						r.r_valid <= 1'b1;
						r.r_data <= mem[rd_idx];
					end
				end
				default: begin
					if (r.b_valid) begin
						if (req.b_ready) begin
							r.b_valid <= 1'b0;
							state <= M_IDLE;
							dly <= pick_delay();
						end
					end else if (dly > 0) begin
						dly <= dly - 1;
					end else begin
						r.b_valid <= 1'b1;
					end
				end
			endcase
		end
	end

endmodule

//--- tb/tb_top.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module tb_top
	import rv_isa_pkg::*;
	import rv_bus_pkg::*;
();

	localparam word_t DATA_D = 32'h817F_F205;
	localparam word_t DATA_E = 32'h7ABC_1234;

	logic     clk;
	logic     rstn;
	logic     restart;
	logic     rand_en;
	axi_req_t m_req;
	axi_rsp_t m_rsp;

	int    errors;
	int    timeouts;
	int    st_off;
	word_t prog [$];
	word_t exp_addr_q [$];
	word_t exp_data_q [$];
	strb_t exp_strb_q [$];
	word_t st_addr_q [$];
	word_t st_data_q [$];
	strb_t st_strb_q [$];
	word_t ar_q [$];

	tb_clock clk_i (
		.restart (restart),
		.clk     (clk),
		.rstn    (rstn)
	);

	tb_axi_mem mem_i (
		.clk     (clk),
		.rstn    (rstn),
		.rand_en (rand_en),
		.req     (m_req),
		.rsp     (m_rsp)
	);

	rv_core dut (
		.clk   (clk),
		.rstn  (rstn),
		.m_req (m_req),
		.m_rsp (m_rsp)
	);

	// bus monitor, aw and w are always taken in the same cycle by the memory
	always @(posedge clk) begin
		if (rstn) begin
			if (m_req.ar_valid && m_rsp.ar_ready) begin
				ar_q.push_back(m_req.ar_addr);
			end
			if (m_req.aw_valid && m_rsp.aw_ready) begin
				st_addr_q.push_back(m_req.aw_addr);
				st_data_q.push_back(m_req.w_data);
				st_strb_q.push_back(m_req.w_strb);
			end
		end
	end

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_strb(input strb_t got, input strb_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	function automatic word_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
			input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `RV_OP_REG};
	endfunction

	function automatic word_t enc_i(input int imm, input int rs1, input int f3, input int rd,
			input logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic word_t enc_s(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], `RV_OP_STORE};
	endfunction

	function automatic word_t enc_b(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			`RV_OP_BRANCH};
	endfunction

	function automatic word_t enc_u(input int imm20, input int rd, input logic [6:0] op);
		return {imm20[19:0], rd[4:0], op};
	endfunction

	function automatic word_t enc_j(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `RV_OP_JAL};
	endfunction

	function automatic word_t lane_mask(input strb_t s);
		word_t m;
		for (int i = 0; i < 4; i++) begin
			m[8*i +: 8] = {8{s[i]}};
		end
		return m;
	endfunction

	// rv32i branch semantics
	function automatic logic branch_taken(input int f3, input word_t a, input word_t b);
		case (f3)
			0: return a == b;
			1: return a != b;
			4: return $signed(a) < $signed(b);
			5: return $signed(a) >= $signed(b);
			6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic word_t ld_expect(input word_t w, input int o, input int f3);
		word_t s;
		s = w >> (8 * o);
		case (f3)
			0: return {{24{s[7]}}, s[7:0]};
			1: return {{16{s[15]}}, s[15:0]};
			4: return {24'b0, s[7:0]};
			5: return {16'b0, s[15:0]};
			default: return s;
		endcase
	endfunction

	function automatic int here();
		return prog.size() * 4;
	endfunction

	task automatic emit(input word_t w);
		prog.push_back(w);
	endtask

	task automatic emit_li(input int rd, input word_t v);
		word_t up;
		up = (v + 32'h800) >> 12;
		emit(enc_u(int'(up), rd, `RV_OP_LUI));
		emit(enc_i(int'(v), rd, 0, rd, `RV_OP_IMM));
	endtask

	task automatic begin_prog();
		prog.delete();
		exp_addr_q.delete();
		exp_data_q.delete();
		exp_strb_q.delete();
		st_off = 0;
	endtask

	task automatic emit_bases();
		emit(enc_i(32'h400, 0, 0, 10, `RV_OP_IMM));     // store area
		emit(enc_i(32'h600, 0, 0, 11, `RV_OP_IMM));     // load data
	endtask

	task automatic expect_store(input word_t a, input word_t d, input strb_t s);
		exp_addr_q.push_back(a);
		exp_data_q.push_back(d);
		exp_strb_q.push_back(s);
	endtask

	task automatic sw_result(input int rs, input word_t val);
		emit(enc_s(st_off, rs, 10, 2));
		expect_store(32'h400 + st_off, val, 4'hf);
		st_off += 4;
	endtask

	task automatic load_and_release(input logic rnd);
		@(posedge clk);
		#1;
		restart = 1'b1;
		rand_en = rnd;
		@(posedge clk);
		@(posedge clk);
		#1;
		for (int i = 0; i < 1024; i++) begin
			mem_i.mem[i] = 32'hA500_0000 ^ (i << 2);
		end
		foreach (prog[i]) begin
			mem_i.mem[i] = prog[i];
		end
		mem_i.mem[384] = DATA_D;
		mem_i.mem[385] = DATA_E;
		ar_q.delete();
		st_addr_q.delete();
		st_data_q.delete();
		st_strb_q.delete();
		restart = 1'b0;
	endtask

	task automatic wait_stores(input int n);
		int t;
		t = 0;
		while (st_data_q.size() < n && t < 8000) begin
			@(posedge clk);
			t++;
		end
		if (st_data_q.size() < n) begin
			timeouts++;
			$display("ERROR at %0t: timed out waiting for %0d store beats, saw %0d", $time, n,
				st_data_q.size());
		end
	endtask

	task automatic wait_ar(input int n);
		int t;
		t = 0;
		while (ar_q.size() < n && t < 2000) begin
			@(posedge clk);
			t++;
		end
		if (ar_q.size() < n) begin
			timeouts++;
			$display("ERROR at %0t: timed out waiting for %0d read addresses", $time, n);
		end
	endtask

	task automatic run_prog(input logic rnd, input string name);
		emit(enc_j(0, 0));     // park in a self loop
		load_and_release(rnd);
		wait_stores(exp_data_q.size());
		for (int i = 0; i < exp_data_q.size() && i < st_data_q.size(); i++) begin
			check_addr(st_addr_q[i], exp_addr_q[i], $sformatf("%s store %0d addr", name, i));
			check_strb(st_strb_q[i], exp_strb_q[i], $sformatf("%s store %0d strb", name, i));
			check_word(st_data_q[i] & lane_mask(exp_strb_q[i]), exp_data_q[i],
				$sformatf("%s store %0d data", name, i));
		end
	endtask

	task automatic test_reset();
		begin_prog();
		emit(enc_j(0, 0));
		@(posedge clk);
		#1;
		restart = 1'b1;
		@(posedge clk);
		@(posedge clk);
		#1;
		check_word({27'b0, m_req.ar_valid, m_req.r_ready, m_req.aw_valid, m_req.w_valid,
			m_req.b_ready}, 32'h0, "valid and ready during reset");
		load_and_release(1'b0);
		wait_ar(1);
		if (ar_q.size() > 0) begin
			check_addr(ar_q[0], `RV_RESET_PC, "first fetch address");
		end
	endtask

	task automatic alu_res(input word_t ins, input word_t exp);
		emit(ins);
		sw_result(5, exp);
	endtask

	task automatic test_alu(input logic rnd);
		word_t a;
		word_t b;
		a = 32'h1234_5678;
		b = 32'hFFFF_FFFB;
		begin_prog();
		emit_bases();
		emit_li(2, a);
		emit(enc_i(-5, 0, 0, 3, `RV_OP_IMM));
		emit(enc_i(7, 0, 0, 14, `RV_OP_IMM));
		sw_result(2, a);
		alu_res(enc_r(0, 3, 2, 0, 5), a + b);
		alu_res(enc_r(32, 3, 2, 0, 5), a - b);
		alu_res(enc_r(0, 3, 2, 4, 5), a ^ b);
		alu_res(enc_r(0, 3, 2, 6, 5), a | b);
		alu_res(enc_r(0, 3, 2, 7, 5), a & b);
		alu_res(enc_r(0, 14, 2, 1, 5), a << 7);
		alu_res(enc_r(0, 14, 3, 5, 5), b >> 7);
		alu_res(enc_r(32, 14, 3, 5, 5), word_t'($signed(b) >>> 7));
		alu_res(enc_r(0, 2, 3, 2, 5), 32'd1);     // -5 < a signed
		alu_res(enc_r(0, 2, 3, 3, 5), 32'd0);
		alu_res(enc_i(-100, 2, 0, 5, `RV_OP_IMM), a + word_t'(-100));
		alu_res(enc_i(32'h0F0, 2, 4, 5, `RV_OP_IMM), a ^ 32'h0F0);
		alu_res(enc_i(32'h70F, 2, 6, 5, `RV_OP_IMM), a | 32'h70F);
		alu_res(enc_i(32'h7F0, 2, 7, 5, `RV_OP_IMM), a & 32'h7F0);
		alu_res(enc_i(4, 2, 1, 5, `RV_OP_IMM), a << 4);
		alu_res(enc_i(4, 3, 5, 5, `RV_OP_IMM), b >> 4);
		alu_res(enc_i(32'h404, 3, 5, 5, `RV_OP_IMM), word_t'($signed(b) >>> 4));
		alu_res(enc_i(-4, 3, 2, 5, `RV_OP_IMM), 32'd1);
		alu_res(enc_i(-4, 3, 3, 5, `RV_OP_IMM), 32'd1);
		alu_res(enc_u(32'hABCDE, 5, `RV_OP_LUI), 32'hABCD_E000);
		emit(enc_i(5, 0, 0, 0, `RV_OP_IMM));     // x0 stays zero
		sw_result(0, 32'h0);
		run_prog(rnd, rnd ? "alu backpressure" : "alu");
	endtask

	task automatic test_control();
		word_t va;
		word_t vb;
		int    ra;
		int    rb;
		int    f3s [6];
		int    link;
		f3s = '{0, 1, 4, 5, 6, 7};
		begin_prog();
		emit_bases();
		emit(enc_i(-5, 0, 0, 1, `RV_OP_IMM));
		emit(enc_i(3, 0, 0, 2, `RV_OP_IMM));
		for (int k = 0; k < 6; k++) begin
			for (int p = 0; p < 3; p++) begin
				ra = (p == 1) ? 2 : 1;
				rb = (p == 0) ? 2 : 1;
				va = (ra == 1) ? 32'hFFFF_FFFB : 32'd3;
				vb = (rb == 1) ? 32'hFFFF_FFFB : 32'd3;
				emit(enc_i(0, 0, 0, 5, `RV_OP_IMM));
				emit(enc_b(8, rb, ra, f3s[k]));
				emit(enc_i(1, 0, 0, 5, `RV_OP_IMM));     // skipped when taken
				sw_result(5, branch_taken(f3s[k], va, vb) ? 32'd0 : 32'd1);
			end
		end
		emit(enc_i(0, 0, 0, 5, `RV_OP_IMM));
		link = here() + 4;
		emit(enc_j(8, 6));
		emit(enc_i(1, 0, 0, 5, `RV_OP_IMM));
		sw_result(5, 32'd0);
		sw_result(6, link);
		emit(enc_i(0, 0, 0, 5, `RV_OP_IMM));
		link = here() + 8;
		emit(enc_u(0, 7, `RV_OP_AUIPC));
		emit(enc_i(13, 7, 0, 6, `RV_OP_JALR));     // odd target, bit 0 dropped
		emit(enc_i(1, 0, 0, 5, `RV_OP_IMM));
		sw_result(5, 32'd0);
		sw_result(6, link);
		run_prog(1'b0, "control");
	endtask

	task automatic test_subword();
		word_t v;
		v = 32'hA1B2_C3D4;
		begin_prog();
		emit_bases();
		emit_li(1, v);
		for (int o = 0; o < 4; o++) begin
			emit(enc_s(st_off + o, 1, 10, 0));
			expect_store(32'h400 + st_off, {24'b0, v[7:0]} << (8 * o), 4'b0001 << o);
			st_off += 4;
		end
		for (int o = 0; o < 4; o += 2) begin
			emit(enc_s(st_off + o, 1, 10, 1));
			expect_store(32'h400 + st_off, {16'b0, v[15:0]} << (8 * o), 4'b0011 << o);
			st_off += 4;
		end
		for (int o = 0; o < 4; o++) begin
			alu_res(enc_i(o, 11, 0, 5, `RV_OP_LOAD), ld_expect(DATA_D, o, 0));
			alu_res(enc_i(o, 11, 4, 5, `RV_OP_LOAD), ld_expect(DATA_D, o, 4));
		end
		for (int o = 0; o < 4; o += 2) begin
			alu_res(enc_i(o, 11, 1, 5, `RV_OP_LOAD), ld_expect(DATA_D, o, 1));
			alu_res(enc_i(o, 11, 5, 5, `RV_OP_LOAD), ld_expect(DATA_D, o, 5));
			alu_res(enc_i(4 + o, 11, 1, 5, `RV_OP_LOAD), ld_expect(DATA_E, o, 1));
		end
		alu_res(enc_i(4, 11, 2, 5, `RV_OP_LOAD), DATA_E);
		run_prog(1'b0, "subword");
	endtask

	task automatic expect_trap(input string name);
		emit(enc_j(0, 0));
		load_and_release(1'b0);
		wait_ar(3);
		if (ar_q.size() >= 3) begin
			check_addr(ar_q[2], `RV_TRAP_VEC, name);
		end
	endtask

	task automatic test_traps();
		begin_prog();
		emit(enc_i(0, 0, 0, 0, `RV_OP_IMM));
		emit(32'hFFFF_FFFF);
		expect_trap("read after illegal instruction");
		begin_prog();
		emit(enc_i(32'h601, 0, 0, 11, `RV_OP_IMM));
		emit(enc_i(0, 11, 2, 5, `RV_OP_LOAD));
		expect_trap("read after misaligned load");
	endtask

	initial begin
		errors = 0;
		timeouts = 0;
		restart = 1'b1;
		rand_en = 1'b0;
		test_reset();
		test_alu(1'b0);
		test_control();
		test_subword();
		test_traps();
		test_alu(1'b1);
		$display("closing: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_bus_pkg.sv
verilog/rv_decoder.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
tb/tb_clock.sv
tb/tb_axi_mem.sv
tb/tb_top.sv

//--- run.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_top \
	--Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log

grep -q '^\*\*\* PASSED \*\*\*$' sim.log
